/* design/cu_decoder.sv */
// Instruction decoder of the compute unit, runs LOAD/STORE itself and hands MATMUL to the sequencer
`timescale 1ns/1ns
`include "nmcu_params.svh"

module cu_decoder (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instr_valid_i,
    input  nmcu_pkg::instr_t   instr_i,
    output logic               busy_o,
    output logic               resp_valid_o,
    output nmcu_pkg::resp_t    resp_o,
    output nmcu_pkg::mem_req_t mem_req_o,
    input  nmcu_pkg::mem_rsp_t mem_rsp_i,
    output logic               mm_start_o,
    output nmcu_pkg::instr_t   mm_instr_o,
    input  logic               mm_done_i,
    input  nmcu_pkg::mem_req_t mm_req_i,
    output nmcu_pkg::mem_rsp_t mm_rsp_o
);

    nmcu_pkg::dec_state_e    state;
    nmcu_pkg::instr_t        instr_q;
    logic [`NMCU_DATA_W-1:0] rdata_q;
    logic                    mm_start_q;
    nmcu_pkg::mem_req_t      own_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= nmcu_pkg::IDLE;
            mm_start_q <= 1'b0;
        end else begin
            mm_start_q <= 1'b0;
            case (state)
                nmcu_pkg::IDLE: begin
                    if (instr_valid_i) begin
                        case (instr_i.opcode)
                            nmcu_pkg::OP_LOAD,
                            nmcu_pkg::OP_STORE: state <= nmcu_pkg::MEM_REQ;
                            nmcu_pkg::OP_MATMUL: begin
                                state      <= nmcu_pkg::MATMUL;
                                mm_start_q <= 1'b1;
                            end
                            // NOP, HALT and unknown opcodes answer right away
                            default: state <= nmcu_pkg::RESPOND;
                        endcase
                    end
                end
                nmcu_pkg::MEM_REQ: state <= nmcu_pkg::MEM_WAIT;
                nmcu_pkg::MEM_WAIT: begin
                    if (mem_rsp_i.valid) begin
                        state <= nmcu_pkg::RESPOND;
                    end
                end
                nmcu_pkg::MATMUL: begin
                    if (mm_done_i) begin
                        state <= nmcu_pkg::RESPOND;
                    end
                end
                default: state <= nmcu_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == nmcu_pkg::IDLE && instr_valid_i) begin
            instr_q <= instr_i;
        end
        if (state == nmcu_pkg::MEM_WAIT && mem_rsp_i.valid) begin
            rdata_q <= mem_rsp_i.rdata;
        end
    end

    always_comb begin
        own_req.valid = (state == nmcu_pkg::MEM_REQ);
        own_req.write = (instr_q.opcode == nmcu_pkg::OP_STORE);
        own_req.addr  = instr_q.addr_a;
        own_req.wdata = instr_q.data;
    end

    // Memory port belongs to the sequencer for the whole MATMUL
    assign mem_req_o      = (state == nmcu_pkg::MATMUL) ? mm_req_i : own_req;
    assign mm_rsp_o.valid = mem_rsp_i.valid && (state == nmcu_pkg::MATMUL);
    assign mm_rsp_o.rdata = mem_rsp_i.rdata;
    assign mm_start_o     = mm_start_q;
    assign mm_instr_o     = instr_q;

    assign busy_o       = (state != nmcu_pkg::IDLE);
    assign resp_valid_o = (state == nmcu_pkg::RESPOND);

    always_comb begin
        case (instr_q.opcode)
            nmcu_pkg::OP_NOP,
            nmcu_pkg::OP_LOAD,
            nmcu_pkg::OP_STORE,
            nmcu_pkg::OP_MATMUL: resp_o.status = nmcu_pkg::ST_OK;
            nmcu_pkg::OP_HALT:   resp_o.status = nmcu_pkg::ST_HALTED;
            default:             resp_o.status = nmcu_pkg::ST_ERROR;
        endcase
        // Only LOAD returns data
        resp_o.data = (instr_q.opcode == nmcu_pkg::OP_LOAD) ? rdata_q : '0;
    end

endmodule

/* design/matmul_sequencer.sv */
// Tile loop of the MATMUL instruction, fetches A and B tiles, streams them and writes back C
`timescale 1ns/1ns
`include "nmcu_params.svh"

module matmul_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  nmcu_pkg::instr_t       instr_i,
    output logic                   done_o,
    output nmcu_pkg::mem_req_t     mem_req_o,
    input  nmcu_pkg::mem_rsp_t     mem_rsp_i,
    output logic                   pe_clear_o,
    output logic                   pe_feed_valid_o,
    output nmcu_pkg::operand_vec_t pe_a_vec_o,
    output nmcu_pkg::operand_vec_t pe_b_vec_o,
    input  logic                   pe_done_i,
    input  nmcu_pkg::psum_tile_t   pe_psum_i
);

    localparam int D = `NMCU_PE_DIM;

    nmcu_pkg::seq_state_e             state;
    logic [`NMCU_LEN_W-1:0]           i_t;
    logic [`NMCU_LEN_W-1:0]           j_t;
    logic [`NMCU_LEN_W-1:0]           k_t;
    logic [`NMCU_LEN_W-1:0]           idx;
    logic [`NMCU_LEN_W-1:0]           row;
    logic [`NMCU_LEN_W-1:0]           col;
    logic [`NMCU_LEN_W-1:0]           stream_cnt;
    logic                             pending;
    logic                             last_elem;
    nmcu_pkg::operand_vec_t [D-1:0]   a_buf;
    nmcu_pkg::operand_vec_t [D-1:0]   b_buf;

    // Element index inside the current tile, row-major
    assign row       = `NMCU_LEN_W'(idx / D);
    assign col       = `NMCU_LEN_W'(idx % D);
    assign last_elem = (idx == `NMCU_LEN_W'(D * D - 1));

    // One element per request, the next one only after its response
    always_comb begin
        mem_req_o.valid = !pending && (state == nmcu_pkg::FETCH_A
            || state == nmcu_pkg::FETCH_B || state == nmcu_pkg::STORE_C);
        mem_req_o.write = (state == nmcu_pkg::STORE_C);
        mem_req_o.wdata = pe_psum_i[row][col][`NMCU_DATA_W-1:0];
        case (state)
            nmcu_pkg::FETCH_B: mem_req_o.addr = instr_i.addr_b
                + `NMCU_ADDR_W'((k_t * D + row) * instr_i.m + j_t * D + col);
            nmcu_pkg::STORE_C: mem_req_o.addr = instr_i.addr_c
                + `NMCU_ADDR_W'((i_t * D + row) * instr_i.m + j_t * D + col);
            default: mem_req_o.addr = instr_i.addr_a
                + `NMCU_ADDR_W'((i_t * D + row) * instr_i.k + k_t * D + col);
        endcase
    end

    // Row r of A and column r of B enter r beats late
    always_comb begin
        int ka;
        pe_feed_valid_o = (state == nmcu_pkg::STREAM);
        pe_clear_o      = pe_feed_valid_o && (stream_cnt == '0) && (k_t == '0);
        for (int r = 0; r < D; r++) begin
            ka = int'(stream_cnt) - r;
            if (pe_feed_valid_o && ka >= 0 && ka < D) begin
                pe_a_vec_o[r] = a_buf[r][ka];
                pe_b_vec_o[r] = b_buf[ka][r];
            end else begin
                pe_a_vec_o[r] = '0;
                pe_b_vec_o[r] = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= nmcu_pkg::DONE;
            i_t        <= '0;
            j_t        <= '0;
            k_t        <= '0;
            idx        <= '0;
            stream_cnt <= '0;
            pending    <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (mem_req_o.valid) begin
                pending <= 1'b1;
            end else if (mem_rsp_i.valid) begin
                pending <= 1'b0;
            end
            case (state)
                nmcu_pkg::DONE: begin
                    if (start_i) begin
                        i_t   <= '0;
                        j_t   <= '0;
                        k_t   <= '0;
                        idx   <= '0;
                        state <= nmcu_pkg::FETCH_A;
                    end
                end
                nmcu_pkg::FETCH_A: begin
                    if (mem_rsp_i.valid) begin
                        idx <= last_elem ? '0 : idx + 1'b1;
                        if (last_elem) begin
                            state <= nmcu_pkg::FETCH_B;
                        end
                    end
                end
                nmcu_pkg::FETCH_B: begin
                    if (mem_rsp_i.valid) begin
                        idx <= last_elem ? '0 : idx + 1'b1;
                        if (last_elem) begin
                            stream_cnt <= '0;
                            state      <= nmcu_pkg::STREAM;
                        end
                    end
                end
                nmcu_pkg::STREAM: begin
                    if (stream_cnt == `NMCU_LEN_W'(2 * D - 2)) begin
                        state <= nmcu_pkg::DRAIN;
                    end else begin
                        stream_cnt <= stream_cnt + 1'b1;
                    end
                end
                nmcu_pkg::DRAIN: begin
                    // K loop ends here, the finished tile is written back
                    if (pe_done_i) begin
                        if ((k_t + 1) * D >= instr_i.k) begin
                            k_t   <= '0;
                            state <= nmcu_pkg::STORE_C;
                        end else begin
                            k_t   <= k_t + 1'b1;
                            state <= nmcu_pkg::FETCH_A;
                        end
                    end
                end
                nmcu_pkg::STORE_C: begin
                    if (mem_rsp_i.valid) begin
                        idx <= last_elem ? '0 : idx + 1'b1;
                        if (last_elem) begin
                            state <= nmcu_pkg::FETCH_A;
                            if ((j_t + 1) * D < instr_i.m) begin
                                j_t <= j_t + 1'b1;
                            end else if ((i_t + 1) * D < instr_i.n) begin
                                j_t <= '0;
                                i_t <= i_t + 1'b1;
                            end else begin
                                state  <= nmcu_pkg::DONE;
                                done_o <= 1'b1;
                            end
                        end
                    end
                end
                default: state <= nmcu_pkg::DONE;
            endcase
        end
    end

    // Tile buffers
    always_ff @(posedge clk) begin
        if (mem_rsp_i.valid && state == nmcu_pkg::FETCH_A) begin
            a_buf[row][col] <= mem_rsp_i.rdata;
        end
        if (mem_rsp_i.valid && state == nmcu_pkg::FETCH_B) begin
            b_buf[row][col] <= mem_rsp_i.rdata;
        end
    end

endmodule

/* design/nmcu_pkg.sv */
// Shared types of the compute unit: opcodes, states, instruction, response and memory structs
`include "nmcu_params.svh"

package nmcu_pkg;

    typedef enum logic [2:0] {
        OP_NOP    = 3'd0,
        OP_LOAD   = 3'd1,
        OP_STORE  = 3'd2,
        OP_MATMUL = 3'd3,
        OP_HALT   = 3'd4
    } opcode_e;

    typedef enum logic [1:0] {
        ST_OK     = 2'd0,
        ST_HALTED = 2'd1,
        ST_ERROR  = 2'd2
    } status_e;

    // Host instruction, addr_a doubles as the LOAD/STORE address
    typedef struct packed {
        opcode_e                 opcode;
        logic [`NMCU_ADDR_W-1:0] addr_a;
        logic [`NMCU_ADDR_W-1:0] addr_b;
        logic [`NMCU_ADDR_W-1:0] addr_c;
        logic [`NMCU_DATA_W-1:0] data;
        logic [`NMCU_LEN_W-1:0]  n;
        logic [`NMCU_LEN_W-1:0]  m;
        logic [`NMCU_LEN_W-1:0]  k;
    } instr_t;

    typedef struct packed {
        status_e                 status;
        logic [`NMCU_DATA_W-1:0] data;
    } resp_t;

    typedef struct packed {
        logic                    valid;
        logic                    write;
        logic [`NMCU_ADDR_W-1:0] addr;
        logic [`NMCU_DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                    valid;
        logic [`NMCU_DATA_W-1:0] rdata;
    } mem_rsp_t;

    // One skewed wavefront, entry r goes to row r (or column r)
    typedef logic [`NMCU_PE_DIM-1:0][`NMCU_DATA_W-1:0] operand_vec_t;

    // Accumulators indexed [row][col]
    typedef logic [`NMCU_PE_DIM-1:0][`NMCU_PE_DIM-1:0][`NMCU_PSUM_W-1:0] psum_tile_t;

    typedef enum logic [2:0] {
        IDLE,
        MEM_REQ,
        MEM_WAIT,
        MATMUL,
        RESPOND
    } dec_state_e;

    // DONE is also the resting state between instructions
    typedef enum logic [2:0] {
        FETCH_A,
        FETCH_B,
        STREAM,
        DRAIN,
        STORE_C,
        DONE
    } seq_state_e;

endpackage

/* design/nmcu_top.sv */
// Top level of the near-memory compute unit, connects decoder, sequencer, PE array and scratchpad
`timescale 1ns/1ns

module nmcu_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             instr_valid_i,
    input  nmcu_pkg::instr_t instr_i,
    output logic             resp_valid_o,
    output nmcu_pkg::resp_t  resp_o,
    output logic             busy_o
);

    nmcu_pkg::mem_req_t     mem_req;
    nmcu_pkg::mem_rsp_t     mem_rsp;
    nmcu_pkg::mem_req_t     mm_req;
    nmcu_pkg::mem_rsp_t     mm_rsp;
    nmcu_pkg::instr_t       mm_instr;
    logic                   mm_start;
    logic                   mm_done;
    logic                   pe_clear;
    logic                   pe_feed_valid;
    logic                   pe_done;
    nmcu_pkg::operand_vec_t pe_a_vec;
    nmcu_pkg::operand_vec_t pe_b_vec;
    nmcu_pkg::psum_tile_t   pe_psum;

    cu_decoder u_decoder (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .busy_o        (busy_o),
        .resp_valid_o  (resp_valid_o),
        .resp_o        (resp_o),
        .mem_req_o     (mem_req),
        .mem_rsp_i     (mem_rsp),
        .mm_start_o    (mm_start),
        .mm_instr_o    (mm_instr),
        .mm_done_i     (mm_done),
        .mm_req_i      (mm_req),
        .mm_rsp_o      (mm_rsp)
    );

    matmul_sequencer u_sequencer (
        .clk             (clk),
        .rst_n           (rst_n),
        .start_i         (mm_start),
        .instr_i         (mm_instr),
        .done_o          (mm_done),
        .mem_req_o       (mm_req),
        .mem_rsp_i       (mm_rsp),
        .pe_clear_o      (pe_clear),
        .pe_feed_valid_o (pe_feed_valid),
        .pe_a_vec_o      (pe_a_vec),
        .pe_b_vec_o      (pe_b_vec),
        .pe_done_i       (pe_done),
        .pe_psum_i       (pe_psum)
    );

    pe_array u_pe_array (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear_i      (pe_clear),
        .feed_valid_i (pe_feed_valid),
        .a_vec_i      (pe_a_vec),
        .b_vec_i      (pe_b_vec),
        .done_o       (pe_done),
        .psum_o       (pe_psum)
    );

    scratchpad_mem u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (mem_req),
        .rsp_o (mem_rsp)
    );

endmodule

/* design/pe_array.sv */
// Output-stationary systolic MAC array, A flows right and B flows down, done marks a drained tile
`timescale 1ns/1ns
`include "nmcu_params.svh"

module pe_array (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clear_i,
    input  logic                   feed_valid_i,
    input  nmcu_pkg::operand_vec_t a_vec_i,
    input  nmcu_pkg::operand_vec_t b_vec_i,
    output logic                   done_o,
    output nmcu_pkg::psum_tile_t   psum_o
);

    localparam int D = `NMCU_PE_DIM;

    // a_q[r][c] passes A from column c to c+1, b_q[r][c] passes B from row r to r+1
    logic [D-1:0][D-2:0][`NMCU_DATA_W-1:0] a_q;
    logic [D-2:0][D-1:0][`NMCU_DATA_W-1:0] b_q;
    logic [D-1:0][D-1:0][`NMCU_DATA_W-1:0] a_in;
    logic [D-1:0][D-1:0][`NMCU_DATA_W-1:0] b_in;
    nmcu_pkg::psum_tile_t                  acc;
    logic [`NMCU_LEN_W-1:0]                drain_cnt;
    logic                                  shift_en;

    assign shift_en = feed_valid_i || (drain_cnt != '0);
    assign done_o   = !feed_valid_i && (drain_cnt == `NMCU_LEN_W'(1));
    assign psum_o   = acc;

    // Zeros are injected at the edges once feeding stops
    always_comb begin
        for (int r = 0; r < D; r++) begin
            a_in[r][0] = feed_valid_i ? a_vec_i[r] : '0;
            b_in[0][r] = feed_valid_i ? b_vec_i[r] : '0;
            for (int c = 1; c < D; c++) begin
                a_in[r][c] = a_q[r][c-1];
                b_in[c][r] = b_q[c-1][r];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_q <= '0;
            b_q <= '0;
        end else if (shift_en) begin
            for (int r = 0; r < D; r++) begin
                for (int c = 0; c < D - 1; c++) begin
                    a_q[r][c] <= a_in[r][c];
                    b_q[c][r] <= b_in[c][r];
                end
            end
        end
    end

    // clear comes with the first beat of a tile, so that beat restarts the sum
    always_ff @(posedge clk) begin
        if (shift_en) begin
            for (int r = 0; r < D; r++) begin
                for (int c = 0; c < D; c++) begin
                    acc[r][c] <= (clear_i ? '0 : acc[r][c])
                        + `NMCU_PSUM_W'(a_in[r][c]) * `NMCU_PSUM_W'(b_in[r][c]);
                end
            end
        end
    end

    // Last wavefront reaches the far corner D-1 cycles after the last beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drain_cnt <= '0;
        end else if (feed_valid_i) begin
            drain_cnt <= `NMCU_LEN_W'(D - 1);
        end else if (drain_cnt != '0) begin
            drain_cnt <= drain_cnt - 1'b1;
        end
    end

endmodule

/* design/scratchpad_mem.sv */
// Single-port scratchpad of the compute unit, each request strobe is answered one cycle later
`timescale 1ns/1ns
`include "nmcu_params.svh"

module scratchpad_mem (
    input  logic               clk,
    input  logic               rst_n,
    input  nmcu_pkg::mem_req_t req_i,
    output nmcu_pkg::mem_rsp_t rsp_o
);

    logic [`NMCU_DATA_W-1:0] mem [2**`NMCU_ADDR_W];
    logic                    rsp_valid_q;
    logic [`NMCU_DATA_W-1:0] rdata_q;

    // Response strobe follows every request, writes included
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i.valid) begin
            if (req_i.write) begin
                mem[req_i.addr] <= req_i.wdata;
            end
            rdata_q <= mem[req_i.addr];
        end
    end

    assign rsp_o.valid = rsp_valid_q;
    assign rsp_o.rdata = rdata_q;

endmodule

/* include/nmcu_params.svh */
// Size macros for the near-memory compute unit, included by the RTL, the package and the testbench
`ifndef NMCU_PARAMS_SVH
`define NMCU_PARAMS_SVH

// Data word carried on the memory and operand paths
`define NMCU_DATA_W 16

// Accumulator width inside each PE
`define NMCU_PSUM_W 32

// Scratchpad address width, 1024 words
`define NMCU_ADDR_W 10

// Width of the N, M and K dimension fields
`define NMCU_LEN_W 8

// Side of the square systolic array
`define NMCU_PE_DIM 2

`endif

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_nmcu
out=$(./obj_dir/Vtb_nmcu)
echo "$out"

if echo "$out" | grep -qF -- '** PASS **'; then
    exit 0
fi
exit 1

/* sim/tb_nmcu.sv */
// Self-checking testbench of the compute unit, compiled through src.f with tb_nmcu as top module
`timescale 1ns/1ns
`include "nmcu_params.svh"

module tb_nmcu;

    localparam int LDST_OPS   = 40;
    localparam int MM_TIMEOUT = 1000;

    // Cycle budget of each test, the watchdog allows twice the sum
    localparam int RESET_CYC    = 8;
    localparam int IDLE_CYC     = 10;
    localparam int LDST_CYC     = LDST_OPS * 5;
    localparam int CODES_CYC    = 3 * 5;
    localparam int MM2_CYC      = 12 * 5 + 60;
    localparam int MM4_CYC      = 80 * 5 + 400;
    localparam int WATCHDOG_CYC = 2 * (RESET_CYC + IDLE_CYC + LDST_CYC + CODES_CYC
                                       + MM2_CYC + MM4_CYC);

    logic             clk;
    logic             rst_n;
    logic             instr_valid_i;
    nmcu_pkg::instr_t instr_i;
    logic             resp_valid_o;
    nmcu_pkg::resp_t  resp_o;
    logic             busy_o;

    // Reference copy of the scratchpad
    logic [`NMCU_DATA_W-1:0] model_mem [2**`NMCU_ADDR_W];
    integer                  seed;
    int                      err_cnt;
    int                      test_cnt;
    int                      test_fail_cnt;

    nmcu_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .resp_valid_o  (resp_valid_o),
        .resp_o        (resp_o),
        .busy_o        (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYC);
        $display("** FAIL **");
        $finish;
    end

    // Called 1 ns after a rising edge, returns there one cycle after the response
    task automatic send_instr(input nmcu_pkg::instr_t ins, input int max_cyc,
                              output nmcu_pkg::resp_t rsp, output int lat);
        logic busy_bad;
        busy_bad      = 1'b0;
        instr_i       = ins;
        instr_valid_i = 1'b1;
        @(posedge clk);
        #1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        lat           = 1;
        while (1) begin
            if (busy_o !== 1'b1) begin
                busy_bad = 1'b1;
            end
            if (resp_valid_o === 1'b1 || lat >= max_cyc) begin
                break;
            end
            @(posedge clk);
            #1;
            lat++;
        end
        if (busy_bad) begin
            $display("Fail at %0t: busy_o expected 1 got 0 while opcode %0d ran",
                     $time, ins.opcode);
            err_cnt++;
        end
        if (resp_valid_o !== 1'b1) begin
            $display("No response to opcode %0d within %0d cycles at %0t",
                     ins.opcode, max_cyc, $time);
            err_cnt++;
            lat = -1;
        end
        rsp = resp_o;
        @(posedge clk);
        #1;
        if (resp_valid_o !== 1'b0) begin
            $display("Fail at %0t: resp_valid_o expected 0 got %b", $time, resp_valid_o);
            err_cnt++;
        end
        if (busy_o !== 1'b0) begin
            $display("Fail at %0t: busy_o expected 0 got %b", $time, busy_o);
            err_cnt++;
        end
    endtask

    task automatic store_word(input logic [`NMCU_ADDR_W-1:0] addr,
                              input logic [`NMCU_DATA_W-1:0] data);
        nmcu_pkg::instr_t ins;
        nmcu_pkg::resp_t  rsp;
        int               lat;
        ins        = '0;
        ins.opcode = nmcu_pkg::OP_STORE;
        ins.addr_a = addr;
        ins.data   = data;
        send_instr(ins, 10, rsp, lat);
        model_mem[addr] = data;
        if (lat >= 0 && lat != 3) begin
            $display("Fail at %0t: STORE resp_valid_o latency expected 3 got %0d", $time, lat);
            err_cnt++;
        end
        if (lat >= 0 && rsp.status !== nmcu_pkg::ST_OK) begin
            $display("Fail at %0t: resp_o.status expected %0d got %0d",
                     $time, nmcu_pkg::ST_OK, rsp.status);
            err_cnt++;
        end
    endtask

    task automatic load_check(input logic [`NMCU_ADDR_W-1:0] addr);
        nmcu_pkg::instr_t ins;
        nmcu_pkg::resp_t  rsp;
        int               lat;
        ins        = '0;
        ins.opcode = nmcu_pkg::OP_LOAD;
        ins.addr_a = addr;
        send_instr(ins, 10, rsp, lat);
        if (lat >= 0 && lat != 3) begin
            $display("Fail at %0t: LOAD resp_valid_o latency expected 3 got %0d", $time, lat);
            err_cnt++;
        end
        if (lat >= 0 && rsp.status !== nmcu_pkg::ST_OK) begin
            $display("Fail at %0t: resp_o.status expected %0d got %0d",
                     $time, nmcu_pkg::ST_OK, rsp.status);
            err_cnt++;
        end
        if (lat >= 0 && rsp.data !== model_mem[addr]) begin
            $display("Fail at %0t: resp_o.data at address %0d expected %h got %h",
                     $time, addr, model_mem[addr], rsp.data);
            err_cnt++;
        end
    endtask

    task automatic simple_op(input nmcu_pkg::opcode_e op, input nmcu_pkg::status_e exp_st);
        nmcu_pkg::instr_t ins;
        nmcu_pkg::resp_t  rsp;
        int               lat;
        ins        = '0;
        ins.opcode = op;
        send_instr(ins, 10, rsp, lat);
        if (lat >= 0 && lat != 1) begin
            $display("Fail at %0t: opcode %0d resp_valid_o latency expected 1 got %0d",
                     $time, op, lat);
            err_cnt++;
        end
        if (lat >= 0 && rsp.status !== exp_st) begin
            $display("Fail at %0t: resp_o.status expected %0d got %0d", $time, exp_st, rsp.status);
            err_cnt++;
        end
    endtask

    // C = A x B over row-major matrices, kept to the data width
    task automatic matmul_model(input int a_base, input int b_base, input int c_base,
                                input int n, input int m, input int k);
        logic [31:0] sum;
        for (int i = 0; i < n; i++) begin
            for (int j = 0; j < m; j++) begin
                sum = '0;
                for (int x = 0; x < k; x++) begin
                    sum = sum + 32'(model_mem[a_base + i * k + x])
                              * 32'(model_mem[b_base + x * m + j]);
                end
                model_mem[c_base + i * m + j] = sum[`NMCU_DATA_W-1:0];
            end
        end
    endtask

    task automatic run_matmul(input int a_base, input int b_base, input int c_base,
                              input int n, input int m, input int k);
        nmcu_pkg::instr_t ins;
        nmcu_pkg::resp_t  rsp;
        int               lat;
        ins        = '0;
        ins.opcode = nmcu_pkg::OP_MATMUL;
        ins.addr_a = `NMCU_ADDR_W'(a_base);
        ins.addr_b = `NMCU_ADDR_W'(b_base);
        ins.addr_c = `NMCU_ADDR_W'(c_base);
        ins.n      = `NMCU_LEN_W'(n);
        ins.m      = `NMCU_LEN_W'(m);
        ins.k      = `NMCU_LEN_W'(k);
        send_instr(ins, MM_TIMEOUT, rsp, lat);
        if (lat >= 0 && rsp.status !== nmcu_pkg::ST_OK) begin
            $display("Fail at %0t: resp_o.status expected %0d got %0d",
                     $time, nmcu_pkg::ST_OK, rsp.status);
            err_cnt++;
        end
        matmul_model(a_base, b_base, c_base, n, m, k);
    endtask

    task automatic fill_random(input int base, input int count);
        logic [31:0] rnd;
        for (int i = 0; i < count; i++) begin
            rnd = $random(seed);
            store_word(`NMCU_ADDR_W'(base + i), rnd[`NMCU_DATA_W-1:0]);
        end
    endtask

    task automatic check_region(input int base, input int count);
        for (int i = 0; i < count; i++) begin
            load_check(`NMCU_ADDR_W'(base + i));
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        test_cnt++;
        if (err_cnt == err_before) begin
            $display("Test %0d %s: ok", test_cnt, name);
        end else begin
            test_fail_cnt++;
            $display("Test %0d %s: failed with %0d errors", test_cnt, name, err_cnt - err_before);
        end
    endtask

    initial begin
        logic [31:0]             rnd;
        logic [`NMCU_ADDR_W-1:0] addr;
        logic [`NMCU_ADDR_W-1:0] written_q [$];
        int                      err_before;
        int                      sel;
        seed          = 32'h2e1c0ec7;
        err_cnt       = 0;
        test_cnt      = 0;
        test_fail_cnt = 0;
        rst_n         = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        repeat (RESET_CYC) @(posedge clk);
        #1;
        rst_n = 1'b1;

        err_before = err_cnt;
        for (int i = 0; i < IDLE_CYC; i++) begin
            @(posedge clk);
            #1;
            if (busy_o !== 1'b0) begin
                $display("Fail at %0t: busy_o expected 0 got %b", $time, busy_o);
                err_cnt++;
            end
            if (resp_valid_o !== 1'b0) begin
                $display("Fail at %0t: resp_valid_o expected 0 got %b", $time, resp_valid_o);
                err_cnt++;
            end
        end
        finish_test("idle after reset", err_before);

        // Loads only go to addresses that hold a stored word
        err_before = err_cnt;
        for (int i = 0; i < LDST_OPS; i++) begin
            rnd = $random(seed);
            if (written_q.size() == 0 || rnd[0]) begin
                addr = rnd[`NMCU_ADDR_W:1];
                store_word(addr, rnd[31:16]);
                written_q.push_back(addr);
            end else begin
                sel = int'(rnd[15:1]) % written_q.size();
                load_check(written_q[sel]);
            end
        end
        finish_test("random store and load", err_before);

        err_before = err_cnt;
        simple_op(nmcu_pkg::OP_NOP, nmcu_pkg::ST_OK);
        simple_op(nmcu_pkg::OP_HALT, nmcu_pkg::ST_HALTED);
        simple_op(nmcu_pkg::opcode_e'(3'd6), nmcu_pkg::ST_ERROR);
        finish_test("nop, halt and unknown opcode", err_before);

        err_before = err_cnt;
        fill_random(500, 4);
        fill_random(520, 4);
        run_matmul(500, 520, 540, 2, 2, 2);
        check_region(540, 4);
        finish_test("matmul 2x2x2", err_before);

        // Four output tiles, two k steps each
        err_before = err_cnt;
        fill_random(100, 16);
        fill_random(200, 16);
        run_matmul(100, 200, 300, 4, 4, 4);
        check_region(300, 16);
        check_region(100, 16);
        check_region(200, 16);
        finish_test("matmul 4x4x4", err_before);

        $display("%0d tests run, %0d failed, %0d errors", test_cnt, test_fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+include
design/nmcu_pkg.sv
design/scratchpad_mem.sv
design/pe_array.sv
design/matmul_sequencer.sv
design/cu_decoder.sv
design/nmcu_top.sv
sim/tb_nmcu.sv
